// File: design/wisc_cfg.svh
`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// datapath widths
`define WISC_WORD_W   16
`define WISC_REG_W    3
`define WISC_OP_W     5
`define WISC_FN_W     2
`define WISC_NREGS    8

// ***********************************************************
// opcodes, instr[15:11]
`define WISC_OP_HALT  5'b00000
`define WISC_OP_NOP   5'b00001
`define WISC_OP_J     5'b00100
`define WISC_OP_ADDI  5'b01000
`define WISC_OP_SUBI  5'b01001
`define WISC_OP_XORI  5'b01010
`define WISC_OP_ANDNI 5'b01011
`define WISC_OP_BEQZ  5'b01100
`define WISC_OP_BNEZ  5'b01101
`define WISC_OP_ST    5'b10000
`define WISC_OP_LD    5'b10001
`define WISC_OP_RFMT  5'b11011  // add/sub/xor/andn group

// R-format funct, instr[1:0]
`define WISC_FN_ADD   2'b00
`define WISC_FN_SUB   2'b01
`define WISC_FN_XOR   2'b10
`define WISC_FN_ANDN  2'b11

`endif

// File: design/wisc_pkg.sv
`default_nettype none

`include "wisc_cfg.svh"

package wisc_pkg;

    typedef logic [`WISC_WORD_W-1:0] word_t;
    typedef logic [`WISC_REG_W-1:0]  reg_idx_t;
    typedef logic [`WISC_OP_W-1:0]   alu_op_t;   // opcode doubles as alu operation
    typedef logic [`WISC_FN_W-1:0]   funct_t;

    // ***********************************************************
    // control bits, zeroed as one unit on a bubble
    typedef struct packed {
        logic alu_src;
        logic branch;
        logic branch_ne;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic reg_write;
        logic jump;
        logic halt;
    } ctrl_t;

    typedef struct packed {
        word_t    pc;
        word_t    read1;
        word_t    read2;
        word_t    imm;
        word_t    jump_addr;
        alu_op_t  alu_op;
        funct_t   funct;
        reg_idx_t write_reg;
        reg_idx_t rs;
        reg_idx_t rt;
        logic     rs_used;
        logic     rt_used;
        ctrl_t    ctrl;
    } decoded_t;

    // pipeline register holds the decode bundle unchanged
    typedef decoded_t idex_t;

    typedef struct packed {
        logic     en;
        reg_idx_t reg_idx;
        word_t    data;
    } wb_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        logic     mem_read;
        logic     mem_write;
        reg_idx_t write_reg;
        logic     reg_write;
        logic     branch_taken;
        word_t    target;
        logic     jump;
        logic     halt;
    } ex_out_t;

endpackage

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "wisc_cfg.svh"

module instr_decoder (
    input  wisc_pkg::word_t    instr,
    input  wisc_pkg::word_t    pc,
    input  wisc_pkg::word_t    read1,
    input  wisc_pkg::word_t    read2,
    output wisc_pkg::reg_idx_t rs,
    output wisc_pkg::reg_idx_t rt,
    output wisc_pkg::decoded_t dec
);

    wisc_pkg::alu_op_t opcode;
    wisc_pkg::word_t   imm5_sx;
    wisc_pkg::word_t   imm8_sx;
    wisc_pkg::word_t   disp11_sx;

    assign opcode = instr[15:11];
    assign rs     = instr[10:8];
    assign rt     = instr[7:5];   // also the store source

    assign imm5_sx   = {{(`WISC_WORD_W-5){instr[4]}}, instr[4:0]};
    assign imm8_sx   = {{(`WISC_WORD_W-8){instr[7]}}, instr[7:0]};
    assign disp11_sx = {{(`WISC_WORD_W-11){instr[10]}}, instr[10:0]};

    // ***********************************************************
    always_comb begin
        dec           = '0;
        dec.pc        = pc;
        dec.read1     = read1;
        dec.read2     = read2;
        dec.rs        = rs;
        dec.rt        = rt;
        dec.funct     = instr[1:0];
        dec.jump_addr = disp11_sx;
        dec.alu_op    = opcode;

        case (opcode)
            `WISC_OP_RFMT: begin
                dec.rs_used        = 1'b1;
                dec.rt_used        = 1'b1;
                dec.write_reg      = instr[4:2];
                dec.ctrl.reg_write = 1'b1;
            end
            `WISC_OP_ADDI, `WISC_OP_SUBI, `WISC_OP_XORI, `WISC_OP_ANDNI: begin
                dec.rs_used        = 1'b1;
                dec.imm            = imm5_sx;
                dec.write_reg      = instr[7:5];
                dec.ctrl.alu_src   = 1'b1;
                dec.ctrl.reg_write = 1'b1;
            end
            `WISC_OP_LD: begin
                dec.rs_used         = 1'b1;
                dec.imm             = imm5_sx;
                dec.write_reg       = instr[7:5];
                dec.ctrl.alu_src    = 1'b1;
                dec.ctrl.mem_read   = 1'b1;
                dec.ctrl.mem_to_reg = 1'b1;
                dec.ctrl.reg_write  = 1'b1;
            end
            `WISC_OP_ST: begin
                dec.rs_used        = 1'b1;
                dec.rt_used        = 1'b1;  // store data
                dec.imm            = imm5_sx;
                dec.ctrl.alu_src   = 1'b1;
                dec.ctrl.mem_write = 1'b1;
            end
            `WISC_OP_BEQZ, `WISC_OP_BNEZ: begin
                dec.rs_used        = 1'b1;
                dec.imm            = imm8_sx;
                dec.ctrl.branch    = 1'b1;
                dec.ctrl.branch_ne = (opcode == `WISC_OP_BNEZ);
            end
            `WISC_OP_J: dec.ctrl.jump = 1'b1;
            `WISC_OP_HALT: dec.ctrl.halt = 1'b1;
            `WISC_OP_NOP: ;
            default: dec.alu_op = `WISC_OP_NOP;  // unknown opcode acts as nop
        endcase
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "wisc_cfg.svh"

module reg_file (
    input  wire                clk,
    input  wire                rst_n,
    input  wisc_pkg::reg_idx_t raddr1,
    input  wisc_pkg::reg_idx_t raddr2,
    output wisc_pkg::word_t    rdata1,
    output wisc_pkg::word_t    rdata2,
    input  wisc_pkg::wb_t      wb
);

    wisc_pkg::word_t [`WISC_NREGS-1:0] regs;

    // write lands on the edge, so the next decode sees it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wb.en) begin
            regs[wb.reg_idx] <= wb.data;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // ***********************************************************
    // write-back from execute must carry a known destination
    wb_idx_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.en |-> !$isunknown(wb.reg_idx)
    ) else $error("reg_file: write-back index unknown while enabled");

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  wisc_pkg::reg_idx_t rs,
    input  wisc_pkg::reg_idx_t rt,
    input  wire                rs_used,
    input  wire                rt_used,
    input  wisc_pkg::reg_idx_t ex_write_reg,
    input  wire                ex_reg_write,
    output logic               stall,
    output logic               control_zero
);

    logic rs_hit;
    logic rt_hit;

    // without forwarding any match against EX costs a cycle
    assign rs_hit = rs_used && (rs == ex_write_reg);
    assign rt_hit = rt_used && (rt == ex_write_reg);

    assign stall        = ex_reg_write && (rs_hit || rt_hit);
    assign control_zero = stall;  // bubble goes in while decode holds

endmodule

`default_nettype wire

// File: design/idex_reg.sv
`timescale 1ns/1ns
`default_nettype none

module idex_reg (
    input  wire                clk,
    input  wire                rst_n,
    input  wisc_pkg::decoded_t dec,
    input  wire                control_zero,
    output wisc_pkg::idex_t    q
);

    wisc_pkg::idex_t d;

    // ***********************************************************
    // data fields pass, side effects dropped on a bubble
    always_comb begin
        d = dec;
        if (control_zero) begin
            d.ctrl = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

    // a bubble in EX must not write the register file or memory
    bubble_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        control_zero |=> (!q.ctrl.reg_write && !q.ctrl.mem_write)
    ) else $error("idex_reg: bubble carries a write enable");

endmodule

`default_nettype wire

// File: design/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "wisc_cfg.svh"

module execute_unit (
    input  wisc_pkg::idex_t   ex,
    input  wisc_pkg::word_t   mem_rdata,
    output wisc_pkg::ex_out_t ex_out,
    output wisc_pkg::word_t   mem_addr,
    output wisc_pkg::wb_t     wb
);

    wisc_pkg::funct_t fn;
    wisc_pkg::word_t  op_b;
    wisc_pkg::word_t  alu_result;
    wisc_pkg::word_t  offset;
    logic             rs_zero;

    assign op_b = ex.ctrl.alu_src ? ex.imm : ex.read2;

    // ***********************************************************
    // immediate forms map onto the R-format functions
    always_comb begin
        case (ex.alu_op)
            `WISC_OP_RFMT:  fn = ex.funct;
            `WISC_OP_SUBI:  fn = `WISC_FN_SUB;
            `WISC_OP_XORI:  fn = `WISC_FN_XOR;
            `WISC_OP_ANDNI: fn = `WISC_FN_ANDN;
            default:        fn = `WISC_FN_ADD;  // addi, ld, st
        endcase
    end

    always_comb begin
        case (fn)
            `WISC_FN_ADD:  alu_result = ex.read1 + op_b;
            `WISC_FN_SUB:  alu_result = ex.read1 - op_b;
            `WISC_FN_XOR:  alu_result = ex.read1 ^ op_b;
            default:       alu_result = ex.read1 & ~op_b;  // andn
        endcase
    end

    assign mem_addr = ex.read1 + ex.imm;

    // branch/jump resolution
    assign rs_zero = (ex.read1 == '0);
    assign offset  = ex.ctrl.jump ? ex.jump_addr : ex.imm;

    always_comb begin
        ex_out              = '0;
        ex_out.alu_result   = alu_result;
        ex_out.store_data   = ex.read2;
        ex_out.mem_read     = ex.ctrl.mem_read;
        ex_out.mem_write    = ex.ctrl.mem_write;
        ex_out.write_reg    = ex.write_reg;
        ex_out.reg_write    = ex.ctrl.reg_write;
        ex_out.branch_taken = ex.ctrl.branch && (ex.ctrl.branch_ne ? !rs_zero : rs_zero);
        ex_out.target       = ex.pc + 16'd2 + offset;
        ex_out.jump         = ex.ctrl.jump;
        ex_out.halt         = ex.ctrl.halt;
    end

    // write-back at the edge that closes this cycle
    assign wb.en      = ex.ctrl.reg_write;
    assign wb.reg_idx = ex.write_reg;
    assign wb.data    = ex.ctrl.mem_to_reg ? mem_rdata : alu_result;

endmodule

`default_nettype wire

// File: design/wisc_idex_top.sv
`timescale 1ns/1ns
`default_nettype none

module wisc_idex_top (
    input  wire               clk,
    input  wire               rst_n,
    input  wisc_pkg::word_t   instr,
    input  wisc_pkg::word_t   pc,
    input  wisc_pkg::word_t   mem_rdata,
    output logic              stall,
    output wisc_pkg::ex_out_t ex_out,
    output wisc_pkg::word_t   mem_addr
);

    wisc_pkg::decoded_t dec;
    wisc_pkg::idex_t    idex_q;
    wisc_pkg::reg_idx_t rs;
    wisc_pkg::reg_idx_t rt;
    wisc_pkg::word_t    rdata1;
    wisc_pkg::word_t    rdata2;
    wisc_pkg::wb_t      wb;
    logic               control_zero;

    // ***********************************************************
    // decode stage
    instr_decoder u_dec (
        .instr (instr),
        .pc    (pc),
        .read1 (rdata1),
        .read2 (rdata2),
        .rs    (rs),
        .rt    (rt),
        .dec   (dec)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    hazard_unit u_haz (
        .rs           (rs),
        .rt           (rt),
        .rs_used      (dec.rs_used),
        .rt_used      (dec.rt_used),
        .ex_write_reg (idex_q.write_reg),
        .ex_reg_write (idex_q.ctrl.reg_write),
        .stall        (stall),
        .control_zero (control_zero)
    );

    idex_reg u_idex (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .control_zero (control_zero),
        .q            (idex_q)
    );

    // execute stage
    execute_unit u_ex (
        .ex        (idex_q),
        .mem_rdata (mem_rdata),
        .ex_out    (ex_out),
        .mem_addr  (mem_addr),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// File: verification/wisc_idex_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "wisc_cfg.svh"

module wisc_idex_tb;

    // cycles over all tests with stalls and drains
    localparam int TEST_CYCLES = 160;
    localparam logic [15:0] NOP_WORD = {`WISC_OP_NOP, 11'd0};

    logic              clk;
    logic              rst_n;
    wisc_pkg::word_t   instr;
    wisc_pkg::word_t   pc;
    wisc_pkg::word_t   mem_rdata;
    logic              stall;
    wisc_pkg::ex_out_t ex_out;
    wisc_pkg::word_t   mem_addr;

    wisc_pkg::word_t   mem [256];
    wisc_pkg::word_t   shadow [8];
    wisc_pkg::word_t   prog [$];
    wisc_pkg::word_t   pc_next;
    logic              issued_valid;
    logic              stall_seen;
    logic              ex_valid;
    logic              ex_bubble;
    wisc_pkg::word_t   ex_instr;
    wisc_pkg::word_t   ex_pc;
    int                checks;
    int                errors;
    int                stall_count;
    int                stall_run;

    wisc_idex_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .stall     (stall),
        .ex_out    (ex_out),
        .mem_addr  (mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ************************************************************
    // memory model answers loads in the same cycle
    assign mem_rdata = mem[mem_addr[7:0]];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 16'(i * 16'h3b1) ^ 16'ha5c3;  // fill pattern
            end
        end else if (ex_out.mem_write) begin
            mem[mem_addr[7:0]] <= ex_out.store_data;
        end
    end

    // track what sits in EX
    always @(posedge clk) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_bubble <= 1'b0;
        end else begin
            ex_valid  <= issued_valid && !stall_seen;
            ex_bubble <= issued_valid && stall_seen;
            ex_instr  <= instr;
            ex_pc     <= pc;
        end
    end

    always @(negedge clk) stall_seen <= stall;

    task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic wisc_pkg::word_t alu(input logic [1:0] fn, input wisc_pkg::word_t a,
                                            input wisc_pkg::word_t b);
        case (fn)
            `WISC_FN_ADD: return a + b;
            `WISC_FN_SUB: return a - b;
            `WISC_FN_XOR: return a ^ b;
            default:      return a & ~b;
        endcase
    endfunction

    // ************************************************************
    // reference model from the ISA rules
    function automatic wisc_pkg::ex_out_t expected_ex(
        input wisc_pkg::word_t ins, input wisc_pkg::word_t ipc,
        input wisc_pkg::word_t regs [8], input wisc_pkg::word_t img [256],
        output logic wb_en, output wisc_pkg::reg_idx_t wb_reg,
        output wisc_pkg::word_t wb_data, output wisc_pkg::word_t addr);
        wisc_pkg::ex_out_t e;
        wisc_pkg::word_t   a;
        wisc_pkg::word_t   b;
        wisc_pkg::word_t   imm5;
        e    = '0;
        a    = regs[ins[10:8]];
        b    = regs[ins[7:5]];
        imm5 = {{11{ins[4]}}, ins[4:0]};
        addr = a + imm5;
        case (ins[15:11])
            `WISC_OP_RFMT: begin
                e.alu_result = alu(ins[1:0], a, b);
                e.write_reg  = ins[4:2];
                e.reg_write  = 1'b1;
            end
            `WISC_OP_ADDI, `WISC_OP_SUBI, `WISC_OP_XORI, `WISC_OP_ANDNI: begin
                e.alu_result = alu(ins[12:11], a, imm5);  // low opcode bits pick the op
                e.write_reg  = ins[7:5];
                e.reg_write  = 1'b1;
            end
            `WISC_OP_LD: begin
                e.mem_read  = 1'b1;
                e.write_reg = ins[7:5];
                e.reg_write = 1'b1;
            end
            `WISC_OP_ST: begin
                e.mem_write  = 1'b1;
                e.store_data = b;
            end
            `WISC_OP_BEQZ, `WISC_OP_BNEZ: begin
                e.branch_taken = (ins[11] ? (a != 16'd0) : (a == 16'd0));
                e.target       = ipc + 16'd2 + {{8{ins[7]}}, ins[7:0]};
            end
            `WISC_OP_J: begin
                e.jump   = 1'b1;
                e.target = ipc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
            end
            `WISC_OP_HALT: e.halt = 1'b1;
            default: ;
        endcase
        wb_en   = e.reg_write;
        wb_reg  = e.write_reg;
        wb_data = e.mem_read ? img[addr[7:0]] : e.alu_result;
        return e;
    endfunction

    // compare process
    always @(negedge clk) begin : compare
        wisc_pkg::ex_out_t  e;
        logic               we;
        wisc_pkg::reg_idx_t wr;
        wisc_pkg::word_t    wd;
        wisc_pkg::word_t    ea;
        logic [4:0]         op;
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) shadow[i] = '0;
            stall_run = 0;
        end else begin
            if (stall) begin
                stall_run++;
                stall_count++;
                assert (stall_run <= 1) else begin
                    $display("stall stayed high for more than one cycle");
                    errors++;
                end
            end else begin
                stall_run = 0;
            end
            if (ex_bubble) begin
                check_bit("bubble reg_write", ex_out.reg_write, 1'b0);
                check_bit("bubble mem_read", ex_out.mem_read, 1'b0);
                check_bit("bubble mem_write", ex_out.mem_write, 1'b0);
                check_bit("bubble branch_taken", ex_out.branch_taken, 1'b0);
                check_bit("bubble jump", ex_out.jump, 1'b0);
                check_bit("bubble halt", ex_out.halt, 1'b0);
            end
            if (ex_valid) begin
                e  = expected_ex(ex_instr, ex_pc, shadow, mem, we, wr, wd, ea);
                op = ex_instr[15:11];
                check_bit("mem_read", ex_out.mem_read, e.mem_read);
                check_bit("mem_write", ex_out.mem_write, e.mem_write);
                check_bit("reg_write", ex_out.reg_write, e.reg_write);
                check_bit("branch_taken", ex_out.branch_taken, e.branch_taken);
                check_bit("jump", ex_out.jump, e.jump);
                check_bit("halt", ex_out.halt, e.halt);
                if (e.reg_write) begin
                    check_word("write_reg", 16'(ex_out.write_reg), 16'(e.write_reg));
                end
                if (e.reg_write && !e.mem_read) begin
                    check_word("alu_result", ex_out.alu_result, e.alu_result);
                end
                if (e.mem_read || e.mem_write) check_word("mem_addr", mem_addr, ea);
                if (e.mem_write) check_word("store_data", ex_out.store_data, e.store_data);
                if (e.jump || op == `WISC_OP_BEQZ || op == `WISC_OP_BNEZ) begin
                    check_word("target", ex_out.target, e.target);
                end
                if (we) shadow[wr] = wd;
            end
        end
    end

    // ************************************************************
    // fetch holds the word while stall is up
    task automatic run_program();
        bit done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (!stall_seen) begin
                if (prog.size() > 0) begin
                    instr        <= prog.pop_front();
                    pc           <= pc_next;
                    pc_next       = pc_next + 16'd2;
                    issued_valid <= 1'b1;
                end else begin
                    instr        <= NOP_WORD;
                    issued_valid <= 1'b0;
                    done          = 1'b1;
                end
            end
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int c0, input int e0);
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    function automatic wisc_pkg::word_t enc_r(input logic [2:0] rs, input logic [2:0] rt,
                                              input logic [2:0] rd, input logic [1:0] fn);
        return {`WISC_OP_RFMT, rs, rt, rd, fn};
    endfunction

    function automatic wisc_pkg::word_t enc_i(input logic [4:0] op, input logic [2:0] rs,
                                              input logic [2:0] rt, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    initial begin : main
        int          c0;
        int          e0;
        int          s0;
        logic [31:0] r;
        logic [4:0]  op;
        logic [2:0]  prev_d;
        logic [2:0]  d;
        wisc_pkg::word_t w;
        void'($urandom(32'h7d70_9d38));
        rst_n = 1'b0;
        instr = NOP_WORD;
        pc = '0;
        pc_next = '0;
        issued_valid = 1'b0;
        checks = 0;
        errors = 0;
        stall_count = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // idle after reset
        c0 = checks;
        e0 = errors;
        repeat (2) begin
            @(negedge clk);
            check_bit("stall", stall, 1'b0);
            check_bit("reg_write", ex_out.reg_write, 1'b0);
            check_bit("mem_read", ex_out.mem_read, 1'b0);
            check_bit("mem_write", ex_out.mem_write, 1'b0);
            check_bit("branch_taken", ex_out.branch_taken, 1'b0);
            check_bit("jump", ex_out.jump, 1'b0);
            check_bit("halt", ex_out.halt, 1'b0);
        end
        end_test("reset", c0, e0);

        // random alu ops independent of the previous one
        c0 = checks;
        e0 = errors;
        s0 = stall_count;
        prev_d = 3'd0;
        for (int i = 0; i < 40; i++) begin
            do begin
                r = $urandom;
                case (r[2:0])
                    3'd3: op = `WISC_OP_ADDI;
                    3'd4: op = `WISC_OP_SUBI;
                    3'd5: op = `WISC_OP_XORI;
                    3'd6: op = `WISC_OP_ANDNI;
                    default: op = `WISC_OP_RFMT;
                endcase
                if (op == `WISC_OP_RFMT) w = enc_r(r[10:8], r[13:11], r[16:14], r[23:22]);
                else w = enc_i(op, r[10:8], r[13:11], r[21:17]);
            end while (i > 0 && (w[10:8] == prev_d || (op == `WISC_OP_RFMT && w[7:5] == prev_d)));
            prev_d = (op == `WISC_OP_RFMT) ? w[4:2] : w[7:5];
            prog.push_back(w);
        end
        run_program();
        assert (stall_count == s0) else begin
            $display("stall raised on independent instructions");
            errors++;
        end
        end_test("alu_random", c0, e0);

        // producer then a dependent consumer of each kind
        c0 = checks;
        e0 = errors;
        s0 = stall_count;
        for (int i = 0; i < 6; i++) begin
            r = $urandom;
            d = r[2:0];
            prog.push_back(enc_i(`WISC_OP_ADDI, r[5:3], d, r[10:6]));
            case (i)
                0: prog.push_back(enc_r(d, r[13:11], r[16:14], r[18:17]));
                1: prog.push_back(enc_r(r[13:11], d, r[16:14], r[18:17]));  // rt side
                2: prog.push_back(enc_i(`WISC_OP_LD, d, r[13:11], r[23:19]));
                3: prog.push_back(enc_i(`WISC_OP_ST, r[13:11], d, r[23:19]));
                4: prog.push_back({`WISC_OP_BEQZ, d, r[31:24]});
                default: prog.push_back({`WISC_OP_BNEZ, d, r[31:24]});
            endcase
            prog.push_back(NOP_WORD);
        end
        run_program();
        assert (stall_count - s0 == 6) else begin
            $display("expected one stall per dependent pair, saw %0d", stall_count - s0);
            errors++;
        end
        end_test("raw_stall", c0, e0);

        // store then load back and read it through the alu
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            prog.push_back(enc_i(`WISC_OP_ST, r[2:0], r[5:3], r[10:6]));
            prog.push_back(NOP_WORD);
            prog.push_back(enc_i(`WISC_OP_LD, r[2:0], r[13:11], r[10:6]));
            prog.push_back(NOP_WORD);
            prog.push_back(enc_r(r[13:11], r[13:11], r[16:14], `WISC_FN_ADD));
        end
        run_program();
        end_test("load_store", c0, e0);

        // branches on a zeroed and a random register then a jump
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 2; i++) begin
            r = $urandom;
            prog.push_back(enc_r(3'd5, 3'd5, 3'd5, `WISC_FN_XOR));
            prog.push_back(NOP_WORD);
            prog.push_back({`WISC_OP_BEQZ, 3'd5, r[7:0]});
            prog.push_back({`WISC_OP_BNEZ, 3'd5, r[15:8]});
            prog.push_back({`WISC_OP_BEQZ, 3'd6, r[23:16]});
            prog.push_back({`WISC_OP_BNEZ, 3'd6, r[31:24]});
            prog.push_back({`WISC_OP_J, r[10:0]});
        end
        run_program();
        end_test("branch_jump", c0, e0);

        // halt, nop and an unused opcode
        c0 = checks;
        e0 = errors;
        prog.push_back({`WISC_OP_HALT, 11'd0});
        prog.push_back(NOP_WORD);
        prog.push_back({`WISC_OP_HALT, 11'd0});
        prog.push_back({5'b11111, 11'h2a5});
        prog.push_back(NOP_WORD);
        run_program();
        end_test("halt_nop", c0, e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TEST_CYCLES * 2 + 100) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: wisc_idex.f
+incdir+design
design/wisc_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/hazard_unit.sv
design/idex_reg.sv
design/execute_unit.sv
design/wisc_idex_top.sv
verification/wisc_idex_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the wisc_idex testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module wisc_idex_tb -f wisc_idex.f -o wisc_idex_sim \
    && ./obj_dir/wisc_idex_sim > sim.log 2>&1 || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
